// ==== vlog.f ====
adma_pkg.sv
burst_if.sv
adma_read_engine.sv
adma_write_engine.sv
adma_sequencer.sv
adma_top.sv
tb_clock_gen.sv
tb_axi_memory.sv
tb_adma.sv

// ==== run.sh ====
#!/bin/sh
set -e

rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_adma \
  -f vlog.f -o sim_adma
./obj_dir/sim_adma > sim.log 2>&1 || true
cat sim.log

if grep -q "NO ERRORS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_adma.sv ====
`timescale 1ns/1ps

module tb_adma import adma_pkg::*; ();

  typedef struct packed {
    logic              c2m;
    logic [1:0]        line_count;
    addr_t [2:0]       line_addr;
    descriptor_t [2:0] line;
    addr_t             data_base;
    irq_t              irq;
    word_t             words;
  } case_t;

  localparam int max_rows = 5;

  logic        clock;
  logic        reset;
  addr_t       araddr;
  logic [7:0]  arlen;
  logic        arvalid;
  logic        arready;
  word_t       rdata;
  logic        rvalid;
  logic        rlast;
  logic        rready;
  addr_t       awaddr;
  logic [7:0]  awlen;
  logic        awvalid;
  logic        awready;
  word_t       wdata;
  logic        wvalid;
  logic        wlast;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        fifo_push;
  word_t       fifo_push_data;
  logic        fifo_pop;
  word_t       fifo_pop_data;
  logic        fifo_word_level;
  logic        fifo_reset;
  logic        dma_enable;
  logic        cmd_complete;
  logic        data_present;
  logic        card_to_mem;
  addr_t       descriptor_pointer;
  logic        xfer_complete;
  logic        int_clear;
  irq_t        dma_interrupts;
  logic        load_en;
  addr_t       load_addr;
  word_t       load_data;
  addr_t       peek_addr;
  word_t       peek_data;

  case_t       cases [max_rows];
  int          row_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  word_t       push_count;
  word_t       pop_count;
  word_t       ar_count;
  word_t       aw_count;
  word_t       fifo_reset_count;
  word_t       pushed [64];
  addr_t       cur_base;
  logic        count_clear;

  tb_clock_gen  u_clock_gen (.*);
  tb_axi_memory u_memory (.*);
  adma_top      DUT (.*);

  ////////////////////////////////////////////////////////////
  // Expected data and descriptor helpers
  ////////////////////////////////////////////////////////////
  function automatic word_t mem_word(input addr_t addr);
    return addr ^ 32'h9e37_79b9;
  endfunction

  // Counting pattern coming from the card
  function automatic word_t card_word(input word_t n);
    return 32'hc0de_0000 + n;
  endfunction

  function automatic descriptor_t make_desc(input logic valid, input logic last,
                                            input logic [1:0] act, input logic [15:0] len,
                                            input addr_t addr);
    descriptor_t d;
    d                        = '0;
    d[desc_valid_bit]        = valid;
    d[desc_end_bit]          = last;
    d[desc_act_lsb +: 2]     = act;
    d[desc_len_lsb +: 16]    = len;
    d[desc_addr_lsb +: 32]   = addr;
    return d;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_irq(input string name, input irq_t got, input irq_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic write_mem(input addr_t addr, input word_t data);
    load_addr = addr;
    load_data = data;
    load_en   = 1'b1;
    next_cycle();
    load_en   = 1'b0;
  endtask

  // Serializer announces one FIFO word per falling edge
  task automatic announce_words(input word_t count);
    int n;
    while (!fifo_reset) next_cycle();
    for (n = 0; n < int'(count); n++) begin
      next_cycle();
      fifo_word_level = 1'b1;
      next_cycle();
      next_cycle();
      fifo_word_level = 1'b0;
      next_cycle();
    end
  endtask

  task automatic add_row(input logic c2m, input addr_t base, input word_t words,
                         input irq_t irq, input logic [1:0] lines,
                         input addr_t a0, input descriptor_t d0,
                         input addr_t a1, input descriptor_t d1,
                         input addr_t a2, input descriptor_t d2);
    case_t c;
    c.c2m        = c2m;
    c.line_count = lines;
    c.line_addr  = {a2, a1, a0};
    c.line       = {d2, d1, d0};
    c.data_base  = base;
    c.irq        = irq;
    c.words      = words;
    cases[row_count] = c;
    row_count++;
  endtask

  // Memory to card, card to memory, no-op and link chain, invalid, repeat after clear
  task automatic build_table();
    add_row(1'b0, 32'h400, 32, 2'b01, 2'd1,
            32'h100, make_desc(1'b1, 1'b1, act_tran, 16'd128, 32'h400), '0, '0, '0, '0);
    add_row(1'b1, 32'h800, 16, 2'b01, 2'd1,
            32'h140, make_desc(1'b1, 1'b1, act_tran, 16'd64, 32'h800), '0, '0, '0, '0);
    add_row(1'b0, 32'h600, 16, 2'b01, 2'd3,
            32'h180, make_desc(1'b1, 1'b0, 2'b00, 16'd64, 32'hc00),
            32'h188, make_desc(1'b1, 1'b0, act_link, 16'd0, 32'h1c0),
            32'h1c0, make_desc(1'b1, 1'b1, act_tran, 16'd64, 32'h600));
    add_row(1'b0, 32'h400, 0, 2'b10, 2'd1,
            32'h200, make_desc(1'b0, 1'b1, act_tran, 16'd64, 32'h400), '0, '0, '0, '0);
    add_row(1'b0, 32'h700, 32, 2'b01, 2'd1,
            32'h240, make_desc(1'b1, 1'b1, act_tran, 16'd128, 32'h700), '0, '0, '0, '0);
  endtask

  ////////////////////////////////////////////////////////////
  // Card FIFO model and bus monitors
  ////////////////////////////////////////////////////////////
  assign fifo_pop_data = card_word(pop_count);

  always @(posedge clock) begin
    if (!reset || count_clear) begin
      push_count       <= '0;
      pop_count        <= '0;
      ar_count         <= '0;
      aw_count         <= '0;
      fifo_reset_count <= '0;
    end else begin
      if (fifo_push) begin
        pushed[push_count[5:0]] <= fifo_push_data;
        push_count              <= push_count + 1;
      end
      if (fifo_pop) begin
        pop_count <= pop_count + 1;
      end
      if (fifo_reset) begin
        fifo_reset_count <= fifo_reset_count + 1;
      end
      // Count data bursts only since descriptor fetches are two beats
      if (arvalid && arready && (arlen == 8'(burst_words - 1))) begin
        check_addr("araddr", araddr, cur_base + addr_t'(ar_count * 64));
        ar_count <= ar_count + 1;
      end
      if (awvalid && awready) begin
        check_addr("awaddr", awaddr, cur_base + addr_t'(aw_count * 64));
        check_word("awlen", word_t'(awlen), word_t'(burst_words - 1));
        aw_count <= aw_count + 1;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if ((cycle_limit > 0) && (cycle_count >= cycle_limit)) begin
      $display("Timeout after %0d cycles, the DMA run did not finish", cycle_count);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Table loop
  ////////////////////////////////////////////////////////////
  initial begin
    int    r;
    int    k;
    int    i;
    int    limit;
    case_t row;
    dma_enable         = 1'b0;
    cmd_complete       = 1'b0;
    data_present       = 1'b0;
    card_to_mem        = 1'b0;
    descriptor_pointer = '0;
    xfer_complete      = 1'b0;
    int_clear          = 1'b0;
    fifo_word_level    = 1'b0;
    load_en            = 1'b0;
    load_addr          = '0;
    load_data          = '0;
    peek_addr          = '0;
    count_clear        = 1'b0;
    cur_base           = '0;
    build_table();
    limit = 0;
    for (r = 0; r < row_count; r++) begin
      limit = limit + 40 * int'(cases[r].words) + 200;
    end
    cycle_limit = limit;
    while (!reset) next_cycle();

    for (r = 0; r < row_count; r++) begin
      row      = cases[r];
      cur_base = row.data_base;
      for (k = 0; k < int'(row.line_count); k++) begin
        write_mem(row.line_addr[k], row.line[k][31:0]);
        write_mem(row.line_addr[k] + 32'd4, row.line[k][63:32]);
      end
      if (!row.c2m) begin
        for (i = 0; i < int'(row.words); i++) begin
          write_mem(row.data_base + addr_t'(4 * i), mem_word(row.data_base + addr_t'(4 * i)));
        end
      end
      count_clear = 1'b1;
      next_cycle();
      count_clear        = 1'b0;
      card_to_mem        = row.c2m;
      descriptor_pointer = row.line_addr[0];
      dma_enable         = 1'b1;
      cmd_complete       = 1'b1;
      data_present       = 1'b1;
      next_cycle();
      dma_enable   = 1'b0;
      cmd_complete = 1'b0;
      data_present = 1'b0;
      if (row.c2m) begin
        announce_words(row.words);
      end
      // Card side reports completion once all words have moved
      while ((row.c2m ? pop_count : push_count) < row.words) next_cycle();
      xfer_complete = 1'b1;
      next_cycle();
      xfer_complete = 1'b0;
      while (dma_interrupts == 2'b00) next_cycle();
      check_irq("dma_interrupts", dma_interrupts, row.irq);
      check_word("push count", push_count, row.c2m ? word_t'(0) : row.words);
      check_word("pop count", pop_count, row.c2m ? row.words : word_t'(0));
      check_word("read burst count", ar_count, row.c2m ? word_t'(0) : row.words / 16);
      check_word("write burst count", aw_count, row.c2m ? row.words / 16 : word_t'(0));
      check_word("fifo_reset pulses", fifo_reset_count,
                 (row.words != 0) ? word_t'(1) : word_t'(0));
      for (i = 0; i < int'(row.words); i++) begin
        if (row.c2m) begin
          peek_addr = row.data_base + addr_t'(4 * i);
          next_cycle();
          check_word("memory word", peek_data, card_word(word_t'(i)));
        end else begin
          check_word("fifo_push_data", pushed[i], mem_word(row.data_base + addr_t'(4 * i)));
        end
      end
      int_clear = 1'b1;
      next_cycle();
      int_clear = 1'b0;
      check_irq("dma_interrupts after clear", dma_interrupts, 2'b00);
    end

    $display("NO ERRORS");
    $finish;
  end

endmodule

// ==== tb_axi_memory.sv ====
`timescale 1ns/1ps

module tb_axi_memory import adma_pkg::*; (
  input  logic       clock,
  input  addr_t      araddr,
  input  logic [7:0] arlen,
  input  logic       arvalid,
  output logic       arready,
  output word_t      rdata,
  output logic       rvalid,
  output logic       rlast,
  input  logic       rready,
  input  addr_t      awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  word_t      wdata,
  input  logic       wvalid,
  input  logic       wlast,
  output logic       wready,
  output logic       bvalid,
  input  logic       bready,
  input  logic       load_en,
  input  addr_t      load_addr,
  input  word_t      load_data,
  input  addr_t      peek_addr,
  output word_t      peek_data
);

  localparam int mem_words = 1024;

  word_t       mem [mem_words];
  addr_t       raddr;
  addr_t       waddr;
  logic [7:0]  rcount;
  logic [31:0] stall;
  integer      seed;

  assign rdata     = mem[raddr[11:2]];
  assign rlast     = rvalid && (rcount == 8'd0);
  assign peek_data = mem[peek_addr[11:2]];

  initial begin
    seed    = 32'h5d24;
    arready = 1'b0;
    awready = 1'b0;
    wready  = 1'b0;
    rvalid  = 1'b0;
    bvalid  = 1'b0;
  end

  always @(posedge clock) begin
    // Ready lines stall at random
    stall = $random(seed);
    arready <= stall[0] | stall[1];
    awready <= stall[2] | stall[3];
    wready  <= stall[4] | stall[5];
    // Read channel, INCR bursts of 4-byte beats
    if (arvalid && arready) begin
      raddr  <= araddr;
      rcount <= arlen;
      rvalid <= 1'b1;
    end else if (rvalid && rready) begin
      if (rcount == 8'd0) begin
        rvalid <= 1'b0;
      end else begin
        raddr  <= raddr + 32'd4;
        rcount <= rcount - 8'd1;
      end
    end
    // Write channel and preload port
    if (awvalid && awready) begin
      waddr <= awaddr;
    end
    if (wvalid && wready) begin
      mem[waddr[11:2]] <= wdata;
      waddr            <= waddr + 32'd4;
      if (wlast) begin
        bvalid <= 1'b1;
      end
    end else if (load_en) begin
      mem[load_addr[11:2]] <= load_data;
    end
    if (bvalid && bready) begin
      bvalid <= 1'b0;
    end
  end

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 8;

  initial begin
    clock = 1'b0;
    forever #half_period clock = ~clock;
  end

  // Reset leaves shortly after a rising edge
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b1;
  end

endmodule

// ==== adma_top.sv ====
`timescale 1ns/1ps

module adma_top import adma_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  // AXI read
  output addr_t      araddr,
  output logic [7:0] arlen,
  output logic       arvalid,
  input  logic       arready,
  input  word_t      rdata,
  input  logic       rvalid,
  input  logic       rlast,
  output logic       rready,
  // AXI write
  output addr_t      awaddr,
  output logic [7:0] awlen,
  output logic       awvalid,
  input  logic       awready,
  output word_t      wdata,
  output logic       wvalid,
  output logic       wlast,
  input  logic       wready,
  input  logic       bvalid,
  output logic       bready,
  // Card FIFO
  output logic       fifo_push,
  output word_t      fifo_push_data,
  output logic       fifo_pop,
  input  word_t      fifo_pop_data,
  input  logic       fifo_word_level,
  output logic       fifo_reset,
  // Control
  input  logic       dma_enable,
  input  logic       cmd_complete,
  input  logic       data_present,
  input  logic       card_to_mem,
  input  addr_t      descriptor_pointer,
  input  logic       xfer_complete,
  input  logic       int_clear,
  output irq_t       dma_interrupts
);

  descriptor_t descriptor;
  logic        fetch;

  burst_if rd_job ();
  burst_if wr_job ();

  ////////////////////////////////////////////////////////////
  // Burst engines
  ////////////////////////////////////////////////////////////
  adma_read_engine u_read_engine (
    .clock          (clock),
    .reset          (reset),
    .job            (rd_job.engine),
    .fetch          (fetch),
    .descriptor     (descriptor),
    .araddr         (araddr),
    .arlen          (arlen),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rvalid         (rvalid),
    .rlast          (rlast),
    .rready         (rready),
    .fifo_push      (fifo_push),
    .fifo_push_data (fifo_push_data)
  );

  adma_write_engine u_write_engine (
    .clock           (clock),
    .reset           (reset),
    .job             (wr_job.engine),
    .fifo_word_level (fifo_word_level),
    .fifo_pop        (fifo_pop),
    .fifo_pop_data   (fifo_pop_data),
    .awaddr          (awaddr),
    .awlen           (awlen),
    .awvalid         (awvalid),
    .awready         (awready),
    .wdata           (wdata),
    .wvalid          (wvalid),
    .wlast           (wlast),
    .wready          (wready),
    .bvalid          (bvalid),
    .bready          (bready)
  );

  // Descriptor chain walker
  adma_sequencer u_sequencer (
    .clock              (clock),
    .reset              (reset),
    .dma_enable         (dma_enable),
    .cmd_complete       (cmd_complete),
    .data_present       (data_present),
    .card_to_mem        (card_to_mem),
    .xfer_complete      (xfer_complete),
    .int_clear          (int_clear),
    .descriptor_pointer (descriptor_pointer),
    .rd_job             (rd_job.issuer),
    .wr_job             (wr_job.issuer),
    .fetch              (fetch),
    .descriptor         (descriptor),
    .fifo_reset         (fifo_reset),
    .dma_interrupts     (dma_interrupts)
  );

endmodule

// ==== adma_sequencer.sv ====
`timescale 1ns/1ps

module adma_sequencer import adma_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        dma_enable,
  input  logic        cmd_complete,
  input  logic        data_present,
  input  logic        card_to_mem,
  input  logic        xfer_complete,
  input  logic        int_clear,
  input  addr_t       descriptor_pointer,
  burst_if.issuer     rd_job,
  burst_if.issuer     wr_job,
  output logic        fetch,
  input  descriptor_t descriptor,
  output logic        fifo_reset,
  output irq_t        dma_interrupts
);

  adma_state_t state;
  addr_t       pointer;
  logic        job_busy;
  logic        job_done;
  logic        xfer_seen;
  logic        start_cond;
  logic        fetch_now;
  logic        xfer_now;
  logic [1:0]  desc_act;
  logic        desc_end;
  addr_t       desc_addr;
  byte_len_t   desc_len;

  // Descriptor fields
  assign desc_act  = descriptor[desc_act_lsb +: 2];
  assign desc_end  = descriptor[desc_end_bit];
  assign desc_addr = descriptor[desc_addr_lsb +: 32];
  assign desc_len  = (descriptor[desc_len_lsb +: 16] == 16'h0000) ?
                     byte_len_t'(17'h10000) : {1'b0, descriptor[desc_len_lsb +: 16]};

  ////////////////////////////////////////////////////////////
  // Job issue
  ////////////////////////////////////////////////////////////
  assign start_cond = (state == st_stop) && dma_enable && cmd_complete && data_present;
  assign fetch_now  = start_cond || ((state == st_fetch) && !job_busy);
  assign xfer_now   = (state == st_transfer) && !job_busy && !job_done;

  assign fetch           = fetch_now;
  assign rd_job.start    = fetch_now || (xfer_now && !card_to_mem);
  // The very first fetch uses the register value directly
  assign rd_job.address  = start_cond ? descriptor_pointer : (fetch_now ? pointer : desc_addr);
  assign rd_job.byte_len = fetch_now ? byte_len_t'(desc_size_bytes) : desc_len;
  assign wr_job.start    = xfer_now && card_to_mem;
  assign wr_job.address  = desc_addr;
  assign wr_job.byte_len = desc_len;
  assign fifo_reset      = xfer_now;

  ////////////////////////////////////////////////////////////
  // ADMA2 state machine
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      state          <= st_stop;
      job_busy       <= 1'b0;
      job_done       <= 1'b0;
      xfer_seen      <= 1'b0;
      dma_interrupts <= '0;
    end else begin
      // Card side completion may come before the engine reports done
      if (xfer_complete) begin
        xfer_seen <= 1'b1;
      end
      case (state)
        st_stop: begin
          if (start_cond) begin
            job_busy  <= 1'b1;
            xfer_seen <= 1'b0;
            state     <= st_fetch;
          end
        end
        st_fetch: begin
          if (fetch_now) begin
            job_busy <= 1'b1;
          end else if (rd_job.done) begin
            job_busy <= 1'b0;
            if (descriptor[desc_valid_bit]) begin
              state <= st_change_addr;
            end else begin
              dma_interrupts[1] <= 1'b1;
              state             <= st_stop;
            end
          end
        end
        st_change_addr: begin
          xfer_seen <= 1'b0;
          // Non-transfer end descriptors only wait for the card
          job_done  <= (desc_act != act_tran);
          if ((desc_act == act_tran) || desc_end) begin
            state <= st_transfer;
          end else begin
            state <= st_fetch;
          end
        end
        st_transfer: begin
          if (xfer_now) begin
            job_busy <= 1'b1;
          end else if (job_busy) begin
            if (rd_job.done || wr_job.done) begin
              job_busy <= 1'b0;
              job_done <= 1'b1;
            end
          end else if (!desc_end) begin
            state <= st_fetch;
          end else if (xfer_seen || xfer_complete) begin
            dma_interrupts[0] <= 1'b1;
            state             <= st_stop;
          end
        end
        default: state <= st_stop;
      endcase
      if (int_clear) begin
        dma_interrupts <= '0;
      end
    end
  end

  // Descriptor pointer, link jumps and everything else steps by one line
  always_ff @(posedge clock) begin
    if (start_cond) begin
      pointer <= descriptor_pointer;
    end else if (state == st_change_addr) begin
      pointer <= (desc_act == act_link) ? desc_addr : pointer + addr_t'(desc_size_bytes);
    end
  end

endmodule

// ==== adma_write_engine.sv ====
`timescale 1ns/1ps

module adma_write_engine import adma_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  burst_if.engine    job,
  input  logic       fifo_word_level,
  output logic       fifo_pop,
  input  word_t      fifo_pop_data,
  output addr_t      awaddr,
  output logic [7:0] awlen,
  output logic       awvalid,
  input  logic       awready,
  output word_t      wdata,
  output logic       wvalid,
  output logic       wlast,
  input  logic       wready,
  input  logic       bvalid,
  output logic       bready
);

  logic       level_meta;
  logic       level_sync;
  logic       level_prev;
  logic       word_fall;
  beat_cnt_t  words_in;
  beat_cnt_t  words_sent;
  beat_cnt_t  word_total;
  logic [3:0] beat_idx;
  logic       busy;
  logic       burst_active;
  logic       beat_ok;

  // Each falling edge of the serializer level is one new FIFO word
  assign word_fall = level_prev && !level_sync;
  assign beat_ok   = wvalid && wready;
  assign fifo_pop  = beat_ok;
  assign wdata     = fifo_pop_data;
  assign wlast     = wvalid && (beat_idx == 4'(burst_words - 1));
  assign awlen     = 8'(burst_words - 1);

  ////////////////////////////////////////////////////////////
  // Word counting and burst control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      level_meta   <= 1'b0;
      level_sync   <= 1'b0;
      level_prev   <= 1'b0;
      words_in     <= '0;
      words_sent   <= '0;
      beat_idx     <= '0;
      busy         <= 1'b0;
      burst_active <= 1'b0;
      awvalid      <= 1'b0;
      wvalid       <= 1'b0;
      bready       <= 1'b0;
      job.done     <= 1'b0;
    end else begin
      level_meta <= fifo_word_level;
      level_sync <= level_meta;
      level_prev <= level_sync;
      job.done   <= 1'b0;
      if (job.start) begin
        busy       <= 1'b1;
        words_in   <= '0;
        words_sent <= '0;
      end else if (word_fall) begin
        words_in <= words_in + 1'b1;
      end
      // A full burst worth of words must be waiting in the FIFO
      if (busy && !burst_active &&
          (words_in >= words_sent + beat_cnt_t'(burst_words))) begin
        burst_active <= 1'b1;
        awvalid      <= 1'b1;
        beat_idx     <= '0;
      end
      if (awvalid && awready) begin
        awvalid <= 1'b0;
        wvalid  <= 1'b1;
      end
      if (beat_ok) begin
        words_sent <= words_sent + 1'b1;
        beat_idx   <= beat_idx + 1'b1;
        if (wlast) begin
          wvalid <= 1'b0;
          bready <= 1'b1;
        end
      end
      if (bready && bvalid) begin
        bready       <= 1'b0;
        burst_active <= 1'b0;
        if (words_sent == word_total) begin
          job.done <= 1'b1;
          busy     <= 1'b0;
        end
      end
    end
  end

  // Burst address steps by 64 bytes after each response
  always_ff @(posedge clock) begin
    if (job.start) begin
      awaddr     <= job.address;
      word_total <= job.byte_len[16:2];
    end else if (bready && bvalid) begin
      awaddr <= awaddr + addr_t'(burst_words * 4);
    end
  end

endmodule

// ==== adma_read_engine.sv ====
`timescale 1ns/1ps

module adma_read_engine import adma_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  burst_if.engine     job,
  input  logic        fetch,
  output descriptor_t descriptor,
  output addr_t       araddr,
  output logic [7:0]  arlen,
  output logic        arvalid,
  input  logic        arready,
  input  word_t       rdata,
  input  logic        rvalid,
  input  logic        rlast,
  output logic        rready,
  output logic        fifo_push,
  output word_t       fifo_push_data
);

  beat_cnt_t beats_left;
  logic      fetch_job;
  logic      beat_ok;

  assign beat_ok        = rvalid && rready;
  // Data beats go straight into the card FIFO
  assign fifo_push      = beat_ok && !fetch_job;
  assign fifo_push_data = rdata;

  ////////////////////////////////////////////////////////////
  // Burst control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      job.done   <= 1'b0;
      beats_left <= '0;
      fetch_job  <= 1'b0;
    end else begin
      job.done <= 1'b0;
      if (job.start) begin
        arvalid    <= 1'b1;
        fetch_job  <= fetch;
        beats_left <= fetch ? beat_cnt_t'(fetch_beats) : job.byte_len[16:2];
      end else if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end else if (beat_ok) begin
        beats_left <= beats_left - 1'b1;
        if (rlast) begin
          rready <= 1'b0;
          // Last beat of the job ends it, otherwise request the next burst
          if (beats_left == beat_cnt_t'(1)) begin
            job.done <= 1'b1;
          end else begin
            arvalid <= 1'b1;
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Address and descriptor capture
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (job.start) begin
      araddr <= job.address;
      arlen  <= fetch ? 8'(fetch_beats - 1) : 8'(burst_words - 1);
    end else if (beat_ok && rlast) begin
      araddr <= araddr + addr_t'(burst_words * 4);
    end
    // Low word arrives first and ends up in the low half
    if (beat_ok && fetch_job) begin
      descriptor <= {rdata, descriptor[63:32]};
    end
  end

endmodule

// ==== burst_if.sv ====
`timescale 1ns/1ps

interface burst_if import adma_pkg::*; ();

  // One job: start pulse with address and length, done pulse back
  logic      start;
  addr_t     address;
  byte_len_t byte_len;
  logic      done;

  modport issuer (
    output start,
    output address,
    output byte_len,
    input  done
  );

  modport engine (
    input  start,
    input  address,
    input  byte_len,
    output done
  );

endinterface

// ==== adma_pkg.sv ====
package adma_pkg;

  // Data and address widths
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] descriptor_t;

  // Byte length needs 17 bits so a zero length field (65536) fits
  typedef logic [16:0] byte_len_t;
  typedef logic [14:0] beat_cnt_t;

  // Bit 0 transfer complete, bit 1 descriptor error
  typedef logic [1:0]  irq_t;

  typedef enum logic [1:0] {
    st_stop,
    st_fetch,
    st_change_addr,
    st_transfer
  } adma_state_t;

  // Burst shape
  localparam int burst_words     = 16;
  localparam int fetch_beats     = 2;
  localparam int desc_size_bytes = 8;

  // Descriptor line layout
  localparam int desc_valid_bit = 0;
  localparam int desc_end_bit   = 1;
  localparam int desc_act_lsb   = 4;
  localparam int desc_len_lsb   = 16;
  localparam int desc_addr_lsb  = 32;

  localparam logic [1:0] act_tran = 2'b10;
  localparam logic [1:0] act_link = 2'b11;

endpackage
